// File: vlog.f
+incdir+logic
logic/rv32_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/instr_decoder.sv
logic/core_control.sv
logic/rv32_core.sv
sim/core_tb.sv

// File: Makefile
VERILATOR  = verilator
FILE_LIST  = vlog.f
TOP        = core_tb
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/core_tb.sv
`timescale 1ns/1ps

`include "rv32_settings.svh"

module core_tb;

    localparam int RANDOM_COUNT = 200;
    // x0..x7 dumped at the end
    localparam int DUMP_COUNT = 8;
    localparam int TOTAL_COUNT = RANDOM_COUNT + DUMP_COUNT;
    // worst case five cycles per instruction, reset fits in the slack
    localparam int CYCLE_LIMIT = 5 * TOTAL_COUNT + 20;

    // funct3 per random pick, reg ops 0..9 and imm ops 10..18
    localparam logic [2:0] REG_FUNCT3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                               3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic [2:0] IMM_FUNCT3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6,
                                              3'd7, 3'd1, 3'd5, 3'd5};

    logic             clk = 1'b0;
    logic             rst = 1'b1;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_rd_data;
    logic [`XLEN-1:0] mem_wr_data;
    logic             mem_wr_ena;
    logic [`XLEN-1:0] pc;
    logic             instruction_done;
    logic [31:0]      instructions_completed;

    // words 0..255 program, 256..511 data region at 0x400..0x7fc
    logic [31:0] mem [0:511];
    logic [31:0] prog [0:255];

    // reference model state
    logic [31:0] model_regs [0:31];
    logic [31:0] model_mem [0:255];
    logic [31:0] model_pc;
    logic [31:0] retired;
    logic        exp_is_load;
    logic        exp_is_store;
    logic [31:0] exp_store_addr;
    logic [31:0] exp_store_data;

    // the fetch cycle right after reset is not sampled
    int cyc_in_instr = 1;
    int cycle_count = 0;

    rv32_core uut (
        .clk                    (clk),
        .rst                    (rst),
        .mem_addr               (mem_addr),
        .mem_rd_data            (mem_rd_data),
        .mem_wr_data            (mem_wr_data),
        .mem_wr_ena             (mem_wr_ena),
        .pc                     (pc),
        .instruction_done       (instruction_done),
        .instructions_completed (instructions_completed)
    );

    always #20 clk = ~clk;

    // asynchronous read port, writes land on the rising edge
    assign mem_rd_data = mem[mem_addr[10:2]];

    always @(posedge clk) begin
        if (mem_wr_ena) begin
            mem[mem_addr[10:2]] <= mem_wr_data;
        end
    end

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_ALU_REG};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
    endfunction

    // sources come from x1..x7
    function automatic logic [4:0] source_reg();
        logic [31:0] n;
        n = $urandom_range(7, 1);
        return n[4:0];
    endfunction

    // rv32i integer semantics, alt is funct7 bit 5
    function automatic logic [31:0] alu_reference(input logic [2:0] f3, input logic alt,
                                                  input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                // kept apart from the logical shift so the sign survives
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // executes one instruction on the model, store target left in exp_store_*
    function automatic void model_execute(input logic [31:0] word);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] addr;
        logic [31:0] value;
        logic        write_rd;
        rd = word[11:7];
        f3 = word[14:12];
        rs1 = word[19:15];
        rs2 = word[24:20];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
        addr = '0;
        value = '0;
        write_rd = 1'b1;
        exp_is_load = 1'b0;
        exp_is_store = 1'b0;
        case (word[6:0])
            `OPC_ALU_REG: value = alu_reference(f3, word[30], model_regs[rs1], model_regs[rs2]);
            // among immediates only srai reads bit 30
            `OPC_ALU_IMM: begin
                value = alu_reference(f3, f3 == 3'b101 && word[30], model_regs[rs1], imm_i);
            end
            `OPC_LOAD: begin
                addr = model_regs[rs1] + imm_i;
                value = model_mem[addr[9:2]];
                exp_is_load = 1'b1;
            end
            default: begin
                addr = model_regs[rs1] + imm_s;
                exp_store_addr = addr;
                exp_store_data = model_regs[rs2];
                model_mem[addr[9:2]] = model_regs[rs2];
                exp_is_store = 1'b1;
                write_rd = 1'b0;
            end
        endcase
        // x0 ignores writes
        if (write_rd && rd != 5'd0) begin
            model_regs[rd] = value;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, got, expected);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic build_program();
        int          sel;
        logic [31:0] r;
        logic [31:0] word;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [2:0]  k;
        logic [11:0] imm;
        logic [11:0] offset;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            sel = $urandom_range(20, 0);
            r = $urandom;
            // rd may be x0 now and then
            rd = {2'b00, r[2:0]};
            // word offsets from x0 inside 0x400..0x7fc
            offset = {2'b01, r[19:12], 2'b00};
            if (sel < 10) begin
                word = r_type_word((sel == 1 || sel == 7) ? 7'h20 : 7'h00,
                                   source_reg(), source_reg(), REG_FUNCT3[sel], rd);
            end else if (sel < 19) begin
                f3 = IMM_FUNCT3[sel - 10];
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    // shamt in the low bits, srai marker at bit 10
                    imm = {1'b0, sel == 18, 5'b00000, r[14:10]};
                end else begin
                    imm = r[31:20];
                end
                word = i_type_word(imm, source_reg(), f3, rd, `OPC_ALU_IMM);
            end else if (sel == 19) begin
                word = i_type_word(offset, 5'd0, 3'b010, rd, `OPC_LOAD);
            end else begin
                word = s_type_word(offset, source_reg(), 5'd0);
            end
            prog[n] = word;
        end
        // register dump into 0x7e0..0x7fc
        for (int n = 0; n < DUMP_COUNT; n++) begin
            k = n[2:0];
            prog[RANDOM_COUNT + n] = s_type_word({7'b0111111, k, 2'b00}, {2'b00, k}, 5'd0);
        end
        // unused slots hold addi x0, x0, <word index>
        for (int n = TOTAL_COUNT; n < 256; n++) begin
            prog[n] = i_type_word(n[11:0], 5'd0, 3'b000, 5'd0, `OPC_ALU_IMM);
        end
        for (int n = 0; n < 256; n++) begin
            mem[n] = prog[n];
            mem[256 + n] = $urandom;
            model_mem[n] = mem[256 + n];
        end
    endtask

    initial begin
        void'($urandom(57068));
        model_pc = `RESET_PC;
        retired = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        repeat (4) @(negedge clk);
        rst <= 1'b0;
    end

    // compare process, one sample per cycle on the falling edge
    always @(negedge clk) begin
        int exp_cycles;
        if (!rst) begin
            cyc_in_instr = cyc_in_instr + 1;
            // pc and count hold still until the end of an instruction
            check_value("pc", pc, model_pc);
            check_value("instructions_completed", instructions_completed, retired);
            if (retired == TOTAL_COUNT) begin
                for (int i = 0; i < 256; i++) begin
                    check_value($sformatf("mem[%0d]", 256 + i), mem[256 + i], model_mem[i]);
                end
                $display("test passed");
                $finish;
            end else if (instruction_done) begin
                model_execute(prog[model_pc[9:2]]);
                exp_cycles = exp_is_load ? 5 : 4;
                check_value("cycles per instruction", cyc_in_instr, exp_cycles);
                check_value("mem_wr_ena", {31'd0, mem_wr_ena}, {31'd0, exp_is_store});
                if (exp_is_store) begin
                    check_value("mem_addr", mem_addr, exp_store_addr);
                    check_value("mem_wr_data", mem_wr_data, exp_store_data);
                end
                model_pc = model_pc + 32'd4;
                retired = retired + 32'd1;
                cyc_in_instr = 0;
            end else begin
                // writes only in the last cycle of a store
                check_value("mem_wr_ena", {31'd0, mem_wr_ena}, 32'd0);
            end
        end
    end

    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: program not finished after %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1, "simulation stopped by timeout");
        end
    end

endmodule

// File: logic/rv32_core.sv
`timescale 1ns/1ps

`include "rv32_settings.svh"

module rv32_core import rv32_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    output logic [`XLEN-1:0] mem_addr,
    input  logic [`XLEN-1:0] mem_rd_data,
    output logic [`XLEN-1:0] mem_wr_data,
    output logic             mem_wr_ena,
    output logic [`XLEN-1:0] pc,
    output logic             instruction_done,
    output logic [31:0]      instructions_completed
);

    core_ctrl_t       ctrl;
    instr_t           ir;
    instr_class_t     instr_class;
    alu_op_t          decoded_op;
    alu_op_t          alu_op;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] imm;

    // non-architectural registers between steps
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] reg_a;
    logic [`XLEN-1:0] reg_b;
    logic [`XLEN-1:0] alu_last;
    logic [`XLEN-1:0] mem_data;

    logic [`XLEN-1:0] rf_data0;
    logic [`XLEN-1:0] rf_data1;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] result;

    instr_decoder u_decoder (
        .instr       (ir),
        .instr_class (instr_class),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .alu_op      (decoded_op)
    );

    core_control u_control (
        .clk                    (clk),
        .rst                    (rst),
        .instr_class            (instr_class),
        .ctrl                   (ctrl),
        .instruction_done       (instruction_done),
        .instructions_completed (instructions_completed)
    );

    // the pc takes the saved pc + 4 in the last cycle of an instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (ctrl.pc_write) begin
            pc <= pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.pc_plus4_write) begin
            pc_plus4 <= alu_result;
        end
        if (ctrl.ir_write) begin
            ir <= mem_rd_data;
        end
        if (ctrl.alu_last_write) begin
            alu_last <= alu_result;
        end
        if (ctrl.mem_data_write) begin
            mem_data <= mem_rd_data;
        end
        // operands follow the ir fields every cycle
        reg_a <= rf_data0;
        reg_b <= rf_data1;
    end

    register_file u_regfile (
        .clk      (clk),
        .rst      (rst),
        .wr_ena   (ctrl.reg_write),
        .wr_addr  (rd),
        .wr_data  (result),
        .rd_addr0 (rs1),
        .rd_addr1 (rs2),
        .rd_data0 (rf_data0),
        .rd_data1 (rf_data1)
    );

    // operand muxes
    assign src_a = (ctrl.src_a == src_a_reg) ? reg_a : pc;

    always_comb begin
        case (ctrl.src_b)
            src_b_reg: src_b = reg_b;
            src_b_imm: src_b = imm;
            default:   src_b = `XLEN'd4;
        endcase
    end

    // address arithmetic and pc increment always add
    assign alu_op = ctrl.use_decoded_op ? decoded_op : alu_add;

    alu u_alu (
        .a      (src_a),
        .b      (src_b),
        .op     (alu_op),
        .result (alu_result)
    );

    assign result = (ctrl.result_sel == result_mem_data) ? mem_data : alu_last;

    // fetch reads at pc and data accesses use the computed address
    assign mem_addr    = ctrl.mem_addr_from_alu ? alu_last : pc;
    assign mem_wr_data = reg_b;
    assign mem_wr_ena  = ctrl.mem_wr_ena;

endmodule

// File: logic/core_control.sv
`timescale 1ns/1ps

module core_control import rv32_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  instr_class_t instr_class,
    output core_ctrl_t   ctrl,
    output logic         instruction_done,
    output logic [31:0]  instructions_completed
);

    core_state_t state;
    core_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch;
        end else begin
            state <= state_next;
        end
    end

    // sequencing per class
    always_comb begin
        state_next = state;
        case (state)
            st_fetch: state_next = st_decode;
            st_decode: begin
                case (instr_class)
                    class_alu_reg, class_alu_imm: state_next = st_execute;
                    class_load, class_store:      state_next = st_mem_addr;
                    // illegal opcode parks the fsm here
                    default:                      state_next = st_decode;
                endcase
            end
            st_execute: state_next = st_alu_wb;
            st_alu_wb:  state_next = st_fetch;
            st_mem_addr: begin
                if (instr_class == class_store) begin
                    state_next = st_mem_write;
                end else begin
                    state_next = st_mem_read;
                end
            end
            st_mem_read:  state_next = st_mem_wb;
            st_mem_wb:    state_next = st_fetch;
            st_mem_write: state_next = st_fetch;
            default:      state_next = st_fetch;
        endcase
    end

    // control fields per state with everything off unless named
    always_comb begin
        ctrl = '0;
        ctrl.src_a = src_a_pc;
        ctrl.src_b = src_b_reg;
        ctrl.result_sel = result_alu_last;
        case (state)
            st_fetch: begin
                // ir <- mem[pc]
                // pc_plus4 <- pc + 4 through the shared alu
                ctrl.ir_write = 1'b1;
                ctrl.pc_plus4_write = 1'b1;
                ctrl.src_a = src_a_pc;
                ctrl.src_b = src_b_four;
            end
            st_execute: begin
                ctrl.alu_last_write = 1'b1;
                ctrl.use_decoded_op = 1'b1;
                ctrl.src_a = src_a_reg;
                if (instr_class == class_alu_imm) begin
                    ctrl.src_b = src_b_imm;
                end
            end
            st_alu_wb: begin
                ctrl.reg_write = 1'b1;
                ctrl.pc_write = 1'b1;
            end
            st_mem_addr: begin
                // rs1 + imm with the op left at add
                ctrl.alu_last_write = 1'b1;
                ctrl.src_a = src_a_reg;
                ctrl.src_b = src_b_imm;
            end
            st_mem_read: begin
                ctrl.mem_addr_from_alu = 1'b1;
                ctrl.mem_data_write = 1'b1;
            end
            st_mem_wb: begin
                ctrl.reg_write = 1'b1;
                ctrl.pc_write = 1'b1;
                ctrl.result_sel = result_mem_data;
            end
            st_mem_write: begin
                ctrl.mem_addr_from_alu = 1'b1;
                ctrl.mem_wr_ena = 1'b1;
                ctrl.pc_write = 1'b1;
            end
            default: begin
                // decode only lets the register file settle into A/B
            end
        endcase
    end

    // the pc moves exactly once in the last cycle of each instruction
    assign instruction_done = ctrl.pc_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            instructions_completed <= '0;
        end else if (instruction_done) begin
            instructions_completed <= instructions_completed + 32'd1;
        end
    end

    no_illegal_in_decode: assert property (@(posedge clk) disable iff (rst)
        (state == st_decode) |-> (instr_class != class_illegal));

    // a memory write belongs to a store that is still held in the ir
    wr_only_in_mem_write: assert property (@(posedge clk) disable iff (rst)
        ctrl.mem_wr_ena |-> (state == st_mem_write && instr_class == class_store));

    done_single_pulse: assert property (@(posedge clk) disable iff (rst)
        instruction_done |=> !instruction_done);

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

`include "rv32_settings.svh"

module instr_decoder import rv32_pkg::*; (
    input  instr_t             instr,
    output instr_class_t       instr_class,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [4:0]         rd,
    output logic [`XLEN-1:0]   imm,
    output alu_op_t            alu_op
);

    // register fields sit at the same bits in every view
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    // opcode classification, the only opcode test in the core
    always_comb begin
        case (instr.r.opcode)
            `OPC_ALU_REG: instr_class = class_alu_reg;
            `OPC_ALU_IMM: instr_class = class_alu_imm;
            `OPC_LOAD:    instr_class = class_load;
            `OPC_STORE:   instr_class = class_store;
            default:      instr_class = class_illegal;
        endcase
    end

    // sign-extended immediate
    // stores take the split s-view, everything else the i-view
    // r-type ignores it since src_b stays on the register
    always_comb begin
        if (instr_class == class_store) begin
            imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
        end else begin
            imm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
        end
    end

    // funct3/funct7 to alu op
    // funct7[5] picks sub and sra; for immediates the same bit is imm[10],
    // which only matters for srai since addi has no subtract form
    always_comb begin
        case (instr.r.funct3)
            3'b000: begin
                if (instr_class == class_alu_reg && instr.r.funct7[5]) begin
                    alu_op = alu_sub;
                end else begin
                    alu_op = alu_add;
                end
            end
            3'b001: alu_op = alu_sll;
            3'b010: alu_op = alu_slt;
            3'b011: alu_op = alu_sltu;
            3'b100: alu_op = alu_xor;
            3'b101: begin
                if (instr.r.funct7[5]) begin
                    alu_op = alu_sra;
                end else begin
                    alu_op = alu_srl;
                end
            end
            3'b110: alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
    end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

`include "rv32_settings.svh"

module register_file import rv32_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_ena,
    input  logic [4:0]       wr_addr,
    input  logic [`XLEN-1:0] wr_data,
    input  logic [4:0]       rd_addr0,
    input  logic [4:0]       rd_addr1,
    output logic [`XLEN-1:0] rd_data0,
    output logic [`XLEN-1:0] rd_data1
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ena && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads with x0 forced to zero
    assign rd_data0 = (rd_addr0 == 5'd0) ? '0 : regs[rd_addr0];
    assign rd_data1 = (rd_addr1 == 5'd0) ? '0 : regs[rd_addr1];

    // the x0 cell keeps its reset value through a write aimed at it
    x0_stays_zero: assert property (@(posedge clk) disable iff (rst)
        (wr_ena && wr_addr == 5'd0) |=> (regs[0] == '0));

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

`include "rv32_settings.svh"

module alu import rv32_pkg::*; (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  alu_op_t          op,
    output logic [`XLEN-1:0] result
);

    // shift amount is the low five bits of b, also for immediates
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            // compares return zero or one
            alu_slt: begin
                result = {{(`XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            alu_sltu: begin
                result = {{(`XLEN-1){1'b0}}, (a < b)};
            end
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            // arithmetic shift keeps the sign bit
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

// File: logic/rv32_pkg.sv
`include "rv32_settings.svh"

package rv32_pkg;

    // r-format view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // i-format view, used by alu immediates and loads
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // s-format view, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // one instruction word, read through whichever view the class calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } instr_t;

    typedef enum logic [2:0] {
        class_alu_reg,
        class_alu_imm,
        class_load,
        class_store,
        class_illegal
    } instr_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_alu_wb,
        st_mem_addr,
        st_mem_read,
        st_mem_wb,
        st_mem_write
    } core_state_t;

    typedef enum logic {
        src_a_pc,
        src_a_reg
    } src_a_t;

    typedef enum logic [1:0] {
        src_b_reg,
        src_b_imm,
        src_b_four
    } src_b_t;

    typedef enum logic {
        result_alu_last,
        result_mem_data
    } result_sel_t;

    // per-cycle datapath steering from the control fsm
    typedef struct packed {
        logic        ir_write;
        logic        pc_write;
        logic        pc_plus4_write;
        logic        alu_last_write;
        logic        mem_data_write;
        logic        reg_write;
        logic        mem_wr_ena;
        logic        mem_addr_from_alu;
        logic        use_decoded_op;
        src_a_t      src_a;
        src_b_t      src_b;
        result_sel_t result_sel;
    } core_ctrl_t;

endpackage

// File: logic/rv32_settings.svh
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// datapath and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// major opcodes handled by the core
// register-register alu group
`define OPC_ALU_REG 7'b0110011
// register-immediate alu group
`define OPC_ALU_IMM 7'b0010011
// lw only, other load sizes are not decoded
`define OPC_LOAD 7'b0000011
// sw only
`define OPC_STORE 7'b0100011

`endif
